/* design/scope_defs.svh */
/*
 * scope capture core defines
 * sample, counter and buffer widths plus the register word map
 */

`ifndef SCOPE_DEFS_SVH
`define SCOPE_DEFS_SVH

// signed adc sample width
`define SCOPE_DW 16
// post-trigger delay counter width
`define SCOPE_CW 16
// buffer address width, 256 samples
`define SCOPE_AW 8

// register word addresses, 9-bit wishbone word space
`define SCOPE_REG_CTRL    9'd0
`define SCOPE_REG_DLY     9'd1
`define SCOPE_REG_TRG     9'd2
`define SCOPE_REG_STS_DLY 9'd3
`define SCOPE_REG_PTR     9'd4
// address bit selecting the buffer window (256..511)
`define SCOPE_BUF_SEL 8

`endif

/* design/scope_pkg.sv */
/*
 * scope capture core types
 * stream beat, trigger configuration and wishbone bundles
 */

`include "scope_defs.svh"

package scope_pkg;

  // one stream beat, sample plus last marker
  typedef struct packed {
    logic signed [`SCOPE_DW-1:0] dat;
    logic                        lst;
  } strm_t;

  // trigger config, laid out as the TRG register bits
  // en in bit 17, edge in bit 16, level in 15:0
  typedef struct packed {
    logic                        en;
    logic                        edg;  // 0 rising, 1 falling
    logic signed [`SCOPE_DW-1:0] lvl;
  } trg_cfg_t;

  // wishbone classic master request
  typedef struct packed {
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [`SCOPE_BUF_SEL:0]  adr;  // word address
    logic [31:0]              dat;
    logic [3:0]               sel;
  } wb_req_t;

  // wishbone slave response
  typedef struct packed {
    logic [31:0] dat;
    logic        ack;
  } wb_rsp_t;

endpackage

/* design/scope_trig.sv */
/*
 * level-crossing trigger detector
 * compares each transferred sample against the one before it
 */

`timescale 1ns/1ps
`include "scope_defs.svh"

module scope_trig (
  input  logic                sti,
  input  logic                ctl_rst,
  input  scope_pkg::trg_cfg_t cfg,
  input  scope_pkg::strm_t    smp,
  input  logic                trn,
  output logic                trg
);

  // previous transferred sample
  logic signed [`SCOPE_DW-1:0] prv;
  // history holds a real sample
  logic                        hst_vld;
  logic                        rise;
  logic                        fall;

  // history flag, first transfer only loads
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      hst_vld <= 1'b0;
    end else if (trn) begin
      hst_vld <= 1'b1;
    end
  end

  always_ff @(posedge sti) begin
    if (trn) begin
      prv <= smp.dat;
    end
  end

  // below then at or above the level
  assign rise = (prv < cfg.lvl) && (smp.dat >= cfg.lvl);
  // above then at or below the level
  assign fall = (prv > cfg.lvl) && (smp.dat <= cfg.lvl);

  // combinational with the current transfer
  assign trg = trn & hst_vld & cfg.en & (cfg.edg ? fall : rise);

endmodule

/* design/scope_acq.sv */
/*
 * acquisition control
 * arm, trigger and post-trigger delay, marks the final beat as last
 */

`timescale 1ns/1ps
`include "scope_defs.svh"

module scope_acq (
  input  logic                 sti,
  input  logic                 ctl_rst,
  input  logic                 ctl_clr,
  input  logic                 ctl_acq,
  input  logic                 ctl_trg,
  input  logic [`SCOPE_CW-1:0] cfg_dly,
  input  scope_pkg::strm_t     sti_dat,
  input  logic                 sti_vld,
  output logic                 sti_rdy,
  output scope_pkg::strm_t     sto_dat,
  output logic                 sto_vld,
  input  logic                 sto_rdy,
  output logic [`SCOPE_CW-1:0] sts_dly,
  output logic                 sts_acq,
  output logic                 sts_trg
);

  localparam logic [`SCOPE_CW-1:0] DLY_ONE = 1;

  logic                        sti_trn;
  logic                        trg_hit;
  logic                        lst_hit;
  logic signed [`SCOPE_DW-1:0] out_dat;
  logic                        out_lst;

  ////////////////////////////////////////////////////////////////////////////
  // transfer, trigger and last detection
  ////////////////////////////////////////////////////////////////////////////

  assign sti_trn = sti_vld & sti_rdy;
  // trigger sample, first hit while armed
  assign trg_hit = sti_trn & sts_acq & ~sts_trg & ctl_trg;
  // zero delay puts last on the trigger sample itself
  assign lst_hit = trg_hit ? (cfg_dly == '0)
                           : (sti_trn & sts_trg & (sts_dly == DLY_ONE));

  // arm and trigger status, delay countdown
  always_ff @(posedge sti) begin
    if (ctl_rst || ctl_clr) begin
      sts_acq <= 1'b0;
      sts_trg <= 1'b0;
      sts_dly <= '0;
    end else begin
      if (ctl_acq && !sts_acq) begin
        sts_acq <= 1'b1;
      end
      if (lst_hit) begin
        // counter empty, disarm
        sts_acq <= 1'b0;
        sts_trg <= 1'b0;
        sts_dly <= '0;
      end else if (trg_hit) begin
        sts_trg <= 1'b1;
        sts_dly <= cfg_dly;
      end else if (sts_trg && sti_trn) begin
        sts_dly <= sts_dly - DLY_ONE;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  // free to load when empty or being drained
  assign sti_rdy = sto_rdy | ~sto_vld;

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      sto_vld <= 1'b0;
      out_lst <= 1'b0;
    end else if (sti_rdy) begin
      // a clear drops the beat in flight
      sto_vld <= sti_vld & sts_acq & ~ctl_clr;
      out_lst <= lst_hit & ~ctl_clr;
    end
  end

  // zeroed while disarmed, input lst ignored
  always_ff @(posedge sti) begin
    if (sti_rdy) begin
      out_dat <= sts_acq ? sti_dat.dat : '0;
    end
  end

  assign sto_dat.dat = out_dat;
  assign sto_dat.lst = out_lst;

endmodule

/* design/scope_buf.sv */
/*
 * circular sample buffer
 * single-ported memory, reads win over stream writes
 */

`timescale 1ns/1ps
`include "scope_defs.svh"

module scope_buf (
  input  logic                        sti,
  input  logic                        ctl_rst,
  input  scope_pkg::strm_t            wr_dat,
  input  logic                        wr_vld,
  output logic                        wr_rdy,
  input  logic                        rd_req,
  input  logic [`SCOPE_AW-1:0]        rd_adr,
  output logic signed [`SCOPE_DW-1:0] rd_dat,
  output logic [`SCOPE_AW-1:0]        end_ptr
);

  // sample memory
  logic signed [`SCOPE_DW-1:0] mem [0:(1<<`SCOPE_AW)-1];
  logic [`SCOPE_AW-1:0]        wr_ptr;
  logic                        wr_trn;

  // stall writes on a read cycle, single port
  assign wr_rdy = ~rd_req;
  assign wr_trn = wr_vld & wr_rdy;

  // write pointer wraps on its own width
  // end pointer tracks the lst beat address
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      wr_ptr  <= '0;
      end_ptr <= '0;
    end else if (wr_trn) begin
      wr_ptr <= wr_ptr + 1'b1;
      if (wr_dat.lst) begin
        end_ptr <= wr_ptr;
      end
    end
  end

  always_ff @(posedge sti) begin
    if (wr_trn) begin
      mem[wr_ptr] <= wr_dat.dat;
    end
  end

  // registered read, valid the cycle after rd_req
  always_ff @(posedge sti) begin
    if (rd_req) begin
      rd_dat <= mem[rd_adr];
    end
  end

endmodule

/* design/scope_regs.sv */
/*
 * wishbone classic register slave
 * control pulses, delay and trigger config, status and buffer reads
 */

`timescale 1ns/1ps
`include "scope_defs.svh"

module scope_regs (
  input  logic                        sti,
  input  logic                        ctl_rst,
  input  scope_pkg::wb_req_t          wb_i,
  output scope_pkg::wb_rsp_t          wb_o,
  input  logic                        sts_acq,
  input  logic                        sts_trg,
  input  logic [`SCOPE_CW-1:0]        sts_dly,
  input  logic [`SCOPE_AW-1:0]        end_ptr,
  input  logic signed [`SCOPE_DW-1:0] rd_dat,
  output logic [`SCOPE_CW-1:0]        cfg_dly,
  output scope_pkg::trg_cfg_t         trg_cfg,
  output logic                        ctl_acq,
  output logic                        ctl_clr,
  output logic                        sw_trg,
  output logic                        rd_req,
  output logic [`SCOPE_AW-1:0]        rd_adr
);

  localparam int TW = $bits(scope_pkg::trg_cfg_t);

  logic        acc;      // new access this cycle
  logic        buf_sel;
  logic        reg_ack;
  logic        buf_ack;
  logic [31:0] reg_dat;
  logic [31:0] wmsk;

  ////////////////////////////////////////////////////////////////////////////
  // access decode
  ////////////////////////////////////////////////////////////////////////////

  // no new access while one is in flight or acked
  assign acc     = wb_i.cyc & wb_i.stb & ~reg_ack & ~buf_ack & ~rd_req;
  assign buf_sel = wb_i.adr[`SCOPE_BUF_SEL];
  assign rd_adr  = wb_i.adr[`SCOPE_AW-1:0];
  // byte lanes
  assign wmsk = {{8{wb_i.sel[3]}}, {8{wb_i.sel[2]}}, {8{wb_i.sel[1]}}, {8{wb_i.sel[0]}}};

  // ack sequencing, register 1 cycle, buffer 2 cycles
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      reg_ack <= 1'b0;
      buf_ack <= 1'b0;
      rd_req  <= 1'b0;
    end else begin
      reg_ack <= acc & ~buf_sel;
      rd_req  <= acc & buf_sel & ~wb_i.we;
      // dropped strobe cancels the late ack
      buf_ack <= rd_req & wb_i.cyc & wb_i.stb;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // register writes and control pulses
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      cfg_dly <= '0;
      trg_cfg <= '0;
      ctl_acq <= 1'b0;
      ctl_clr <= 1'b0;
      sw_trg  <= 1'b0;
    end else begin
      // pulses last one cycle
      ctl_acq <= 1'b0;
      ctl_clr <= 1'b0;
      sw_trg  <= 1'b0;
      if (acc && wb_i.we && !buf_sel) begin
        case (wb_i.adr)
          `SCOPE_REG_CTRL: begin
            ctl_acq <= wb_i.dat[0] & wb_i.sel[0];
            ctl_clr <= wb_i.dat[1] & wb_i.sel[0];
            sw_trg  <= wb_i.dat[2] & wb_i.sel[0];
          end
          `SCOPE_REG_DLY: begin
            cfg_dly <= (cfg_dly & ~wmsk[`SCOPE_CW-1:0]) |
                       (wb_i.dat[`SCOPE_CW-1:0] & wmsk[`SCOPE_CW-1:0]);
          end
          `SCOPE_REG_TRG: begin
            trg_cfg <= scope_pkg::trg_cfg_t'((trg_cfg & ~wmsk[TW-1:0]) |
                                             (wb_i.dat[TW-1:0] & wmsk[TW-1:0]));
          end
          default: ;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read data
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (acc && !buf_sel) begin
      case (wb_i.adr)
        `SCOPE_REG_CTRL:    reg_dat <= {30'd0, sts_trg, sts_acq};
        `SCOPE_REG_DLY:     reg_dat <= 32'(cfg_dly);
        `SCOPE_REG_TRG:     reg_dat <= 32'(trg_cfg);
        `SCOPE_REG_STS_DLY: reg_dat <= 32'(sts_dly);
        `SCOPE_REG_PTR:     reg_dat <= 32'(end_ptr);
        default:            reg_dat <= '0;
      endcase
    end
  end

  // buffer data arrives with its ack, sign-extended
  assign wb_o.dat = buf_ack ? {{(32-`SCOPE_DW){rd_dat[`SCOPE_DW-1]}}, rd_dat} : reg_dat;
  assign wb_o.ack = reg_ack | buf_ack;

endmodule

/* design/scope_top.sv */
/*
 * oscilloscope capture core top level
 * adc stream through trigger, acquisition and buffer, wishbone access
 */

`timescale 1ns/1ps
`include "scope_defs.svh"

module scope_top (
  input  logic               sti,
  input  logic               ctl_rst,
  input  scope_pkg::strm_t   adc_dat,
  input  logic               adc_vld,
  output logic               adc_rdy,
  input  scope_pkg::wb_req_t wb_i,
  output scope_pkg::wb_rsp_t wb_o
);

  // configuration and control
  logic [`SCOPE_CW-1:0] cfg_dly;
  scope_pkg::trg_cfg_t  trg_cfg;
  logic                 ctl_acq;
  logic                 ctl_clr;
  logic                 sw_trg;
  logic                 hw_trg;
  // status
  logic [`SCOPE_CW-1:0] sts_dly;
  logic                 sts_acq;
  logic                 sts_trg;
  logic [`SCOPE_AW-1:0] end_ptr;
  // acquisition to buffer hop
  scope_pkg::strm_t     acq_dat;
  logic                 acq_vld;
  logic                 acq_rdy;
  // buffer read port
  logic                        rd_req;
  logic [`SCOPE_AW-1:0]        rd_adr;
  logic signed [`SCOPE_DW-1:0] rd_dat;

  ////////////////////////////////////////////////////////////////////////////
  // stream chain
  ////////////////////////////////////////////////////////////////////////////

  // trigger only watches adc transfers
  scope_trig trig_i (
    .sti     (sti),
    .ctl_rst (ctl_rst),
    .cfg     (trg_cfg),
    .smp     (adc_dat),
    .trn     (adc_vld & adc_rdy),
    .trg     (hw_trg)
  );

  scope_acq acq_i (
    .sti     (sti),
    .ctl_rst (ctl_rst),
    .ctl_clr (ctl_clr),
    .ctl_acq (ctl_acq),
    .ctl_trg (hw_trg | sw_trg),
    .cfg_dly (cfg_dly),
    .sti_dat (adc_dat),
    .sti_vld (adc_vld),
    .sti_rdy (adc_rdy),
    .sto_dat (acq_dat),
    .sto_vld (acq_vld),
    .sto_rdy (acq_rdy),
    .sts_dly (sts_dly),
    .sts_acq (sts_acq),
    .sts_trg (sts_trg)
  );

  scope_buf buf_i (
    .sti     (sti),
    .ctl_rst (ctl_rst),
    .wr_dat  (acq_dat),
    .wr_vld  (acq_vld),
    .wr_rdy  (acq_rdy),
    .rd_req  (rd_req),
    .rd_adr  (rd_adr),
    .rd_dat  (rd_dat),
    .end_ptr (end_ptr)
  );

  // register slave
  scope_regs regs_i (
    .sti     (sti),
    .ctl_rst (ctl_rst),
    .wb_i    (wb_i),
    .wb_o    (wb_o),
    .sts_acq (sts_acq),
    .sts_trg (sts_trg),
    .sts_dly (sts_dly),
    .end_ptr (end_ptr),
    .rd_dat  (rd_dat),
    .cfg_dly (cfg_dly),
    .trg_cfg (trg_cfg),
    .ctl_acq (ctl_acq),
    .ctl_clr (ctl_clr),
    .sw_trg  (sw_trg),
    .rd_req  (rd_req),
    .rd_adr  (rd_adr)
  );

endmodule

/* test/scope_assert.sv */
/*
 * bound protocol checks
 * wishbone ack, stream hold and arm status
 */

`timescale 1ns/1ps

module scope_assert (
  input logic             sti,
  input logic             ctl_rst,
  input logic             cyc,
  input logic             stb,
  input logic             ack,
  input logic             acq,
  input logic             trg,
  input scope_pkg::strm_t dat,
  input logic             vld,
  input logic             rdy
);

  // ack only inside an active cycle
  ack_in_cycle: assert property (@(posedge sti) disable iff (ctl_rst)
    ack |-> (cyc && stb))
    else $error("wishbone ack outside cyc and stb");

  trg_needs_acq: assert property (@(posedge sti) disable iff (ctl_rst)
    trg |-> acq)
    else $error("sts_trg high while disarmed");

  // beat held until taken
  vld_held: assert property (@(posedge sti) disable iff (ctl_rst)
    (vld && !rdy) |=> (vld && $stable(dat)))
    else $error("stream beat changed before transfer");

  // empty output stays empty while disarmed
  no_vld_disarmed: assert property (@(posedge sti) disable iff (ctl_rst)
    (!acq && !vld) |=> !vld)
    else $error("stream valid raised while disarmed");

endmodule

// stream side, bus inputs idle
bind scope_acq scope_assert acq_chk_i (
  .sti     (sti),
  .ctl_rst (ctl_rst),
  .cyc     (1'b0),
  .stb     (1'b0),
  .ack     (1'b0),
  .acq     (sts_acq),
  .trg     (sts_trg),
  .dat     (sto_dat),
  .vld     (sto_vld),
  .rdy     (sto_rdy)
);

// bus side, stream inputs idle
bind scope_regs scope_assert regs_chk_i (
  .sti     (sti),
  .ctl_rst (ctl_rst),
  .cyc     (wb_i.cyc),
  .stb     (wb_i.stb),
  .ack     (wb_o.ack),
  .acq     (sts_acq),
  .trg     (sts_trg),
  .dat     (scope_pkg::strm_t'(0)),
  .vld     (1'b0),
  .rdy     (1'b1)
);

/* test/scope_tb.sv */
/*
 * directed testbench for the scope capture core
 * drives adc ramps and wishbone accesses, checks captured samples
 */

`timescale 1ns/1ps
`include "scope_defs.svh"

module scope_tb;

  // upper bounds over all tests
  localparam int SMP_BUDGET = 600;
  localparam int ACC_BUDGET = 240;
  // a buffer read with its strobe drop takes at most 4 cycles
  localparam int WDOG_CYC = 2 * (SMP_BUDGET + 4 * ACC_BUDGET) + 50;

  logic               sti;
  logic               ctl_rst;
  scope_pkg::strm_t   adc_dat;
  logic               adc_vld;
  logic               adc_rdy;
  scope_pkg::wb_req_t wb_i;
  scope_pkg::wb_rsp_t wb_o;

  logic [31:0] lfsr;
  int          n_chk;
  int          n_err;
  int          stall_cnt;

  scope_top dut_i (
    .sti     (sti),
    .ctl_rst (ctl_rst),
    .adc_dat (adc_dat),
    .adc_vld (adc_vld),
    .adc_rdy (adc_rdy),
    .wb_i    (wb_i),
    .wb_o    (wb_o)
  );

  initial begin
    sti = 1'b0;
    forever #5 sti = ~sti;
  end

  // watchdog
  initial begin
    #(WDOG_CYC * 10);
    $display("timeout: tests still running after %0d cycles, %0d errors so far",
             WDOG_CYC, n_err);
    $display("Test failures found");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // right-shifting galois lfsr
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic int take_bits(input int n);
    int v;
    int i;
    v = 0;
    for (i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr[0]);
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  task automatic expect_word(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    n_chk++;
    if (got !== exp) begin
      n_err++;
      $display("[ERROR] wb_o.dat (%s): got %h, expected %h", name, got, exp);
    end
  endtask

  // tasks start and end just after a falling edge
  // strobe held through the ack cycle and dropped on the next falling edge
  task automatic wb_write(input logic [8:0] adr, input logic [31:0] dat);
    wb_i.cyc = 1'b1;
    wb_i.stb = 1'b1;
    wb_i.we  = 1'b1;
    wb_i.adr = adr;
    wb_i.dat = dat;
    wb_i.sel = 4'hf;
    do begin
      @(negedge sti);
    end while (!wb_o.ack);
    @(negedge sti);
    wb_i = '0;
  endtask

  task automatic wb_read(input logic [8:0] adr, output logic [31:0] dat);
    wb_i.cyc = 1'b1;
    wb_i.stb = 1'b1;
    wb_i.we  = 1'b0;
    wb_i.adr = adr;
    wb_i.dat = '0;
    wb_i.sel = 4'hf;
    do begin
      @(negedge sti);
    end while (!wb_o.ack);
    dat = wb_o.dat;
    @(negedge sti);
    wb_i = '0;
  endtask

  // sample i is first + i*step and is held until adc_rdy takes it
  task automatic send_ramp(input int first, input int step, input int num);
    int   i;
    logic took;
    for (i = 0; i < num; i++) begin
      adc_dat.dat = 16'(first + i * step);
      adc_dat.lst = 1'b0;
      adc_vld     = 1'b1;
      do begin
        // rdy only depends on registered state
        took = adc_rdy;
        if (!took) begin
          stall_cnt++;
        end
        @(negedge sti);
      end while (!took);
    end
    adc_vld = 1'b0;
  endtask

  // word at end_ptr and then idle status
  task automatic check_capture(input string name, input int last_smp);
    logic [31:0] ptr;
    logic [31:0] rd;
    wb_read(`SCOPE_REG_PTR, ptr);
    wb_read({1'b1, ptr[`SCOPE_AW-1:0]}, rd);
    expect_word(name, rd, 32'(last_smp));
    wb_read(`SCOPE_REG_CTRL, rd);
    expect_word("ctrl status", rd, 32'h0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_readback();
    logic [31:0] rd;
    wb_read(`SCOPE_REG_STS_DLY, rd);
    expect_word("sts_dly", rd, 32'h0);
    wb_read(`SCOPE_REG_PTR, rd);
    expect_word("end_ptr", rd, 32'h0);
    wb_write(`SCOPE_REG_DLY, 32'hdead_5a3c);
    wb_read(`SCOPE_REG_DLY, rd);
    // 16-bit counter
    expect_word("cfg_dly", rd, 32'h0000_5a3c);
    // only 18 bits kept and the enable stays off
    wb_write(`SCOPE_REG_TRG, 32'hfffd_a5a5);
    wb_read(`SCOPE_REG_TRG, rd);
    expect_word("trg_cfg", rd, 32'hfffd_a5a5 & 32'h0003_ffff);
  endtask

  task automatic soft_trigger_capture();
    int k;
    int n;
    k = take_bits(4) + 2;
    n = take_bits(5);
    wb_write(`SCOPE_REG_DLY, 32'(n));
    wb_write(`SCOPE_REG_CTRL, 32'h1);
    // ctrl write starts after k ramp edges so the pulse lands on index k+1
    fork
      send_ramp(0, 1, k + n + 10);
      begin
        repeat (k) @(negedge sti);
        wb_write(`SCOPE_REG_CTRL, 32'h4);
      end
    join
    check_capture("soft trigger last sample", k + 1 + n);
  endtask

  task automatic rising_capture();
    int lvl;
    int n;
    lvl = take_bits(6) + 10;
    n = take_bits(5);
    wb_write(`SCOPE_REG_DLY, 32'(n));
    wb_write(`SCOPE_REG_TRG, 32'h0002_0000 | 32'(lvl));
    wb_write(`SCOPE_REG_CTRL, 32'h1);
    send_ramp(0, 1, lvl + n + 8);
    // first ramp value at or above lvl is lvl
    check_capture("rising trigger last sample", lvl + n);
  endtask

  task automatic falling_capture();
    int lvl;
    int n;
    lvl = take_bits(6) + 10;
    n = take_bits(5);
    wb_write(`SCOPE_REG_DLY, 32'(n));
    wb_write(`SCOPE_REG_TRG, 32'h0003_0000 | 32'(lvl));
    wb_write(`SCOPE_REG_CTRL, 32'h1);
    send_ramp(lvl + 20, -1, 20 + n + 8);
    // may go negative and reads back sign-extended
    check_capture("falling trigger last sample", lvl - n);
  endtask

  task automatic disarmed_and_clear();
    logic [31:0] ptr0;
    logic [31:0] rd;
    wb_read(`SCOPE_REG_PTR, ptr0);
    // soft and level triggers at 50 while disarmed
    wb_write(`SCOPE_REG_TRG, 32'h0002_0032);
    wb_write(`SCOPE_REG_CTRL, 32'h4);
    send_ramp(0, 1, 60);
    wb_read(`SCOPE_REG_PTR, rd);
    expect_word("end_ptr while disarmed", rd, ptr0);
    wb_read(`SCOPE_REG_CTRL, rd);
    expect_word("ctrl status while disarmed", rd, 32'h0);
    // trigger at 50 then 9 more beats of a 40 beat delay
    wb_write(`SCOPE_REG_DLY, 32'd40);
    wb_write(`SCOPE_REG_CTRL, 32'h1);
    send_ramp(0, 1, 60);
    wb_read(`SCOPE_REG_CTRL, rd);
    expect_word("ctrl status mid capture", rd, 32'h3);
    wb_read(`SCOPE_REG_STS_DLY, rd);
    expect_word("sts_dly mid capture", rd, 32'(40 - (59 - 50)));
    wb_write(`SCOPE_REG_CTRL, 32'h2);
    wb_read(`SCOPE_REG_CTRL, rd);
    expect_word("ctrl status after clear", rd, 32'h0);
    // enough beats to reach lst if the capture were still running
    send_ramp(60, 1, 40);
    wb_read(`SCOPE_REG_PTR, rd);
    expect_word("end_ptr after clear", rd, ptr0);
  endtask

  task automatic backpressure_capture();
    int          n;
    int          cap;
    int          k;
    logic [31:0] ptr;
    logic [31:0] rd;
    n = take_bits(5) + 8;
    // ramp 900 up to the trigger at 1000 and n beyond
    cap = 100 + n + 1;
    stall_cnt = 0;
    wb_write(`SCOPE_REG_DLY, 32'(n));
    wb_write(`SCOPE_REG_TRG, 32'h0002_0000 | 32'd1000);
    wb_write(`SCOPE_REG_CTRL, 32'h1);
    fork
      send_ramp(900, 1, cap + 8);
      begin
        for (k = 0; k < 12; k++) begin
          wb_read(9'h100 | 9'(k * 5), rd);
        end
      end
    join
    n_chk++;
    if (stall_cnt == 0) begin
      n_err++;
      $display("adc_rdy never dropped while the buffer was being read");
    end
    wb_read(`SCOPE_REG_PTR, ptr);
    for (k = 0; k < cap; k++) begin
      wb_read({1'b1, ptr[`SCOPE_AW-1:0] - 8'(k)}, rd);
      expect_word("buffer word behind end_ptr", rd, 32'(1000 + n - k));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    lfsr      = 32'h0eda_5c86;
    n_chk     = 0;
    n_err     = 0;
    stall_cnt = 0;
    ctl_rst   = 1'b1;
    adc_dat   = '0;
    adc_vld   = 1'b0;
    wb_i      = '0;
    repeat (2) @(posedge sti);
    @(negedge sti);
    ctl_rst = 1'b0;
    check_readback();
    soft_trigger_capture();
    rising_capture();
    falling_capture();
    disarmed_and_clear();
    backpressure_capture();
    $display("summary: %0d checks, %0d errors", n_chk, n_err);
    if (n_err == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* scope_top.f */
+incdir+design
design/scope_pkg.sv
design/scope_trig.sv
design/scope_acq.sv
design/scope_buf.sv
design/scope_regs.sv
design/scope_top.sv
test/scope_assert.sv
test/scope_tb.sv

/* Makefile */
# Verilator simulation of the scope capture core

VERILATOR ?= verilator
TOP       ?= scope_tb
FLIST     ?= scope_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Test failures found
PASS_MSG  ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o $(TOP)
	-./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
